// ==== build.f ====
+incdir+rtl
rtl/video_mode_pkg.sv
rtl/video_raster_pkg.sv
rtl/video_sync.sv
rtl/video_fetch.sv
rtl/video_render.sv
rtl/video_palette.sv
rtl/video_top.sv
tb/tb_video_top.sv

// ==== build.sh ====
#!/bin/sh
# compile the video subsystem testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_video_top -f build.f \
	--Mdir obj_dir -o sim_video > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_video > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "SIMULATION PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== rtl/video_config.svh ====
// raster geometry and fetch sizing macros, included by the video RTL and the testbench
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// visible pixels on each line
`define VID_H_ACTIVE 64

// full line length in c1 beats, blanking included
`define VID_H_TOTAL 80

// visible lines per frame
`define VID_V_ACTIVE 8

// full frame height in lines
`define VID_V_TOTAL 10

// outstanding memory reads allowed
// same as the word FIFO depth so a returned word always has a slot
`define VID_CREDITS 4

// frames between flash phase changes
`define VID_FLASH_DIV 2

`endif

// ==== rtl/video_fetch.sv ====
// video word prefetch from external memory with credit flow control, word FIFO and underrun flag
`timescale 1ns/1ns
`include "video_config.svh"

module video_fetch (
	input  logic        clk,
	input  logic        rst,
	input  logic        frame_start,
	input  logic        word_take,
	input  logic [15:0] frame_base,
	output logic        mem_req,
	output logic [15:0] mem_addr,
	input  logic        mem_rvalid,
	input  logic [31:0] mem_rdata,
	output logic [31:0] data,
	output logic        word_ok,
	output logic        underrun
);
	localparam int DEPTH = `VID_CREDITS;
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [31:0]   fifo [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic [CW-1:0] credits;
	logic [CW-1:0] outstanding;
	logic [CW-1:0] drop;
	logic          run;
	logic          dropping;
	logic          push;
	logic          pop;

	// idle until the first frame start has loaded the base address
	assign mem_req = run && (credits != '0) && !frame_start;

	// replies to reads issued before a flush belong to the old frame
	assign dropping = mem_rvalid && (drop != '0);
	assign push = mem_rvalid && (drop == '0) && !frame_start;
	assign pop = word_take && (count != '0);

	// credits + count + outstanding stays at DEPTH
	always_ff @(posedge clk) begin
		if (rst) begin
			run         <= 1'b0;
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			credits     <= CW'(DEPTH);
			outstanding <= '0;
			drop        <= '0;
		end else begin
			outstanding <= outstanding + CW'(mem_req) - CW'(mem_rvalid);
			if (frame_start) begin
				run     <= 1'b1;
				wr_ptr  <= '0;
				rd_ptr  <= '0;
				count   <= '0;
				// queued words free their slots now, in-flight ones on arrival
				credits <= credits + count + CW'(mem_rvalid);
				drop    <= outstanding - CW'(mem_rvalid);
			end else begin
				if (push)
					wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
				if (pop)
					rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
				if (dropping)
					drop <= drop - 1'b1;
				count   <= count + CW'(push) - CW'(pop);
				credits <= credits - CW'(mem_req) + CW'(pop) + CW'(dropping);
			end
		end
	end

	// linear address walk from the frame base
	always_ff @(posedge clk) begin
		if (frame_start)
			mem_addr <= frame_base;
		else if (mem_req)
			mem_addr <= mem_addr + 16'd1;
	end

	// word storage and the word on display
	always_ff @(posedge clk) begin
		if (push)
			fifo[wr_ptr] <= mem_rdata;
		if (pop)
			data <= fifo[rd_ptr];
	end

	// starved take leaves word_ok low for the whole word
	always_ff @(posedge clk) begin
		if (rst) begin
			word_ok  <= 1'b0;
			underrun <= 1'b0;
		end else if (word_take) begin
			word_ok <= count != '0;
			if (count == '0)
				underrun <= 1'b1;
		end
	end

	// every request has a FIFO slot reserved for its reply
	assert property (@(posedge clk) disable iff (rst)
		mem_req |-> (({1'b0, count} + {1'b0, outstanding}) < (CW + 1)'(DEPTH)));

	// memory only answers reads that were issued
	assert property (@(posedge clk) disable iff (rst)
		mem_rvalid |-> (outstanding != '0));

endmodule

// ==== rtl/video_mode_pkg.sv ====
// render mode, palette index and colour types shared by the renderer, palette and testbench
package video_mode_pkg;

	// pixel format of the video words
	typedef enum logic [1:0] {
		rm_zx = 2'd0,
		rm_hc = 2'd1,
		rm_xc = 2'd2,
		rm_tx = 2'd3
	} render_mode_t;

	// index into the 256 entry palette
	typedef logic [7:0] pal_index_t;

	// 5 bits per channel, red on top
	typedef struct packed {
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
	} rgb_t;

	// upper nibble of the index for 16 colour pixels
	localparam logic [3:0] hc_bank = 4'hE;

	// upper nibble for zx and text pixels
	localparam logic [3:0] zx_bank = 4'hF;

endpackage

// ==== rtl/video_palette.sv ====
// palette RAM, maps the 8-bit pixel index to 15-bit rgb with a registered read
`timescale 1ns/1ns

module video_palette (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       pal_we,
	input  video_mode_pkg::pal_index_t pal_addr,
	input  video_mode_pkg::rgb_t       pal_wdata,
	input  video_mode_pkg::pal_index_t vplex,
	input  logic                       vplex_valid,
	output video_mode_pkg::rgb_t       rgb,
	output logic                       rgb_valid
);
	import video_mode_pkg::*;

	rgb_t ram [256];

	// write port, same-address read in this cycle still sees the old entry
	always_ff @(posedge clk) begin
		if (pal_we)
			ram[pal_addr] <= pal_wdata;
	end

	// lookup once per rendered pixel
	// rgb holds between beats
	always_ff @(posedge clk) begin
		if (vplex_valid)
			rgb <= ram[vplex];
	end

	always_ff @(posedge clk) begin
		if (rst)
			rgb_valid <= 1'b0;
		else
			rgb_valid <= vplex_valid;
	end

endmodule

// ==== rtl/video_raster_pkg.sv ====
// raster counter and pixel select types shared by the timing generator, renderer and testbench
package video_raster_pkg;

	// horizontal position in c1 beats
	typedef logic [7:0] hcount_t;

	// line number inside the frame
	typedef logic [7:0] vcount_t;

	// pixel position inside the current video word
	// zx and text words span all 16 values
	typedef logic [3:0] psel_t;

endpackage

// ==== rtl/video_render.sv ====
// pixel renderer, turns the current video word into a palette index for zx, 16c, 256c and text
`timescale 1ns/1ns

module video_render (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         c1,
	input  logic                         hvpix,
	input  logic                         nogfx,
	input  logic                         flash,
	input  logic                         hires,
	input  video_raster_pkg::psel_t      psel,
	input  video_mode_pkg::render_mode_t render_mode,
	input  logic [31:0]                  data,
	input  logic                         word_ok,
	input  video_mode_pkg::pal_index_t   border,
	output video_mode_pkg::pal_index_t   vplex,
	output logic                         vplex_valid
);
	import video_mode_pkg::*;

	logic [15:0] zx_gfx;
	logic [15:0] zx_atr;
	logic        zx_dot;
	logic [7:0]  zx_attr;
	logic        zx_ink;
	logic [3:0]  hc_dot;
	pal_index_t  zx_pix;
	pal_index_t  tx_pix;
	pal_index_t  hc_pix;
	pal_index_t  xc_pix;
	pal_index_t  pixel;
	pal_index_t  plex;
	logic [3:0]  prev_nib;

	// zx word: bitmap low, attributes high, one attribute per 8 pixels
	assign zx_gfx = data[15:0];
	assign zx_atr = data[31:16];
	// msb of each bitmap byte is the leftmost pixel
	assign zx_dot = zx_gfx[{psel[3], ~psel[2:0]}];
	assign zx_attr = psel[3] ? zx_atr[15:8] : zx_atr[7:0];

	// flash bit swaps ink and paper on the odd phase
	assign zx_ink = zx_dot ^ (flash & zx_attr[7]);
	assign zx_pix = {zx_bank, zx_attr[6], zx_ink ? zx_attr[2:0] : zx_attr[5:3]};

	// text shares the zx dot, attribute is ink low nibble, paper high
	assign tx_pix = {zx_bank, zx_dot ? zx_attr[3:0] : zx_attr[7:4]};

	// 16c, high nibble of each byte goes first
	always_comb begin
		case (psel[1:0])
			2'd0: hc_dot = data[7:4];
			2'd1: hc_dot = data[3:0];
			2'd2: hc_dot = data[15:12];
			default: hc_dot = data[11:8];
		endcase
	end
	assign hc_pix = {hc_bank, hc_dot};

	// 256c, byte is the index
	assign xc_pix = psel[0] ? data[15:8] : data[7:0];

	always_comb begin
		case (render_mode)
			rm_hc:   pixel = hc_pix;
			rm_xc:   pixel = xc_pix;
			rm_tx:   pixel = tx_pix;
			default: pixel = zx_pix;
		endcase
	end

	// starved word shows as border too
	assign plex = (hvpix && !nogfx && word_ok) ? pixel : border;

	always_ff @(posedge clk) begin
		if (rst)
			vplex_valid <= 1'b0;
		else
			vplex_valid <= c1;
	end

	// hi-res packs two pixels, the older one in the upper nibble
	always_ff @(posedge clk) begin
		if (c1) begin
			prev_nib <= plex[3:0];
			vplex    <= hires ? {prev_nib, plex[3:0]} : plex;
		end
	end

endmodule

// ==== rtl/video_sync.sv ====
// raster timing generator, makes c1, the active-area flag, pixel select and word-take strobes
`timescale 1ns/1ns
`include "video_config.svh"

module video_sync (
	input  logic                         clk,
	input  logic                         rst,
	input  video_mode_pkg::render_mode_t mode,
	input  logic                         hires,
	output logic                         c1,
	output logic                         hvpix,
	output video_raster_pkg::psel_t      psel,
	output logic                         word_take,
	output logic                         frame_start,
	output logic                         flash
);
	import video_mode_pkg::*;
	import video_raster_pkg::*;

	// active area sits at the right end of the line
	// so the blank from (0,0) gives the fetch time to refill after a frame flush
	localparam int H_START = `VID_H_TOTAL - `VID_H_ACTIVE;
	localparam int FW = ($clog2(`VID_FLASH_DIV) > 0) ? $clog2(`VID_FLASH_DIV) : 1;

	hcount_t    hcount;
	vcount_t    vcount;
	logic [4:0] word_len;
	logic [4:0] step;
	logic       last_pix;
	logic       line_end;
	logic       frame_end;
	logic       line_due;
	logic [FW-1:0] frame_cnt;

	// psel units per word for each mode
	always_comb begin
		case (mode)
			rm_hc:   word_len = 5'd4;
			rm_xc:   word_len = 5'd2;
			default: word_len = 5'd16;
		endcase
	end

	// hi-res shows a pixel for half the time, two psel steps per beat
	assign step = hires ? 5'd2 : 5'd1;
	assign last_pix = ({1'b0, psel} + step) >= word_len;

	assign line_end = hcount == hcount_t'(`VID_H_TOTAL - 1);
	assign frame_end = line_end && (vcount == vcount_t'(`VID_V_TOTAL - 1));
	assign hvpix = (hcount >= hcount_t'(H_START)) && (vcount < vcount_t'(`VID_V_ACTIVE));

	// beat just ahead of the first pixel of a visible line
	assign line_due = (hcount == hcount_t'(H_START - 1)) && (vcount < vcount_t'(`VID_V_ACTIVE));

	assign frame_start = c1 && (hcount == '0) && (vcount == '0);

	// no take after the last word of a line, the next line prefetches its own
	assign word_take = c1 && ((hvpix && last_pix && !line_end) || line_due);

	always_ff @(posedge clk) begin
		if (rst) begin
			c1     <= 1'b0;
			hcount <= '0;
			vcount <= '0;
			psel   <= '0;
		end else begin
			c1 <= ~c1;
			if (c1) begin
				hcount <= line_end ? '0 : hcount + 1'b1;
				if (line_end)
					vcount <= frame_end ? '0 : vcount + 1'b1;
				// restart at every word boundary and outside the picture
				psel <= (hvpix && !last_pix) ? psel + step[3:0] : '0;
			end
		end
	end

	// flash phase flips every VID_FLASH_DIV frames
	always_ff @(posedge clk) begin
		if (rst) begin
			frame_cnt <= '0;
			flash     <= 1'b0;
		end else if (c1 && frame_end) begin
			if (frame_cnt == FW'(`VID_FLASH_DIV - 1)) begin
				frame_cnt <= '0;
				flash     <= ~flash;
			end else begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	// renderer never indexes past the word of the current mode
	assert property (@(posedge clk) disable iff (rst)
		c1 |-> ({1'b0, psel} < word_len));

endmodule

// ==== rtl/video_top.sv ====
// video output subsystem top, raster timing, memory fetch, renderer and palette
`timescale 1ns/1ns

module video_top (
	input  logic                         clk,
	input  logic                         rst,
	input  video_mode_pkg::render_mode_t render_mode,
	input  logic                         hires,
	input  logic                         nogfx,
	input  video_mode_pkg::pal_index_t   border,
	input  logic [15:0]                  frame_base,
	output logic                         mem_req,
	output logic [15:0]                  mem_addr,
	input  logic                         mem_rvalid,
	input  logic [31:0]                  mem_rdata,
	input  logic                         pal_we,
	input  video_mode_pkg::pal_index_t   pal_addr,
	input  video_mode_pkg::rgb_t         pal_wdata,
	output logic                         underrun,
	output video_mode_pkg::pal_index_t   vplex,
	output logic                         vplex_valid,
	output video_mode_pkg::rgb_t         rgb,
	output logic                         rgb_valid
);
	import video_raster_pkg::*;

	logic        c1;
	logic        hvpix;
	logic        word_take;
	logic        frame_start;
	logic        flash;
	psel_t       psel;
	logic [31:0] data;
	logic        word_ok;

	// timing, runs free and never waits on memory
	video_sync u_sync (
		.clk(clk),
		.rst(rst),
		.mode(render_mode),
		.hires(hires),
		.c1(c1),
		.hvpix(hvpix),
		.psel(psel),
		.word_take(word_take),
		.frame_start(frame_start),
		.flash(flash)
	);

	video_fetch u_fetch (
		.clk(clk),
		.rst(rst),
		.frame_start(frame_start),
		.word_take(word_take),
		.frame_base(frame_base),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_rvalid(mem_rvalid),
		.mem_rdata(mem_rdata),
		.data(data),
		.word_ok(word_ok),
		.underrun(underrun)
	);

	// one clk from the c1 beat to vplex
	video_render u_render (
		.clk(clk),
		.rst(rst),
		.c1(c1),
		.hvpix(hvpix),
		.nogfx(nogfx),
		.flash(flash),
		.hires(hires),
		.psel(psel),
		.render_mode(render_mode),
		.data(data),
		.word_ok(word_ok),
		.border(border),
		.vplex(vplex),
		.vplex_valid(vplex_valid)
	);

	// second clk, index to colour
	video_palette u_palette (
		.clk(clk),
		.rst(rst),
		.pal_we(pal_we),
		.pal_addr(pal_addr),
		.pal_wdata(pal_wdata),
		.vplex(vplex),
		.vplex_valid(vplex_valid),
		.rgb(rgb),
		.rgb_valid(rgb_valid)
	);

endmodule

// ==== tb/tb_video_top.sv ====
// testbench for video_top, runs frame-aligned tests against a latency memory model and a pixel reference
`timescale 1ns/1ns
`include "video_config.svh"

module tb_video_top;
	import video_mode_pkg::*;
	import video_raster_pkg::*;

	localparam int NT = 9;
	localparam int H_START = `VID_H_TOTAL - `VID_H_ACTIVE;
	localparam int FRAME_BEATS = `VID_H_TOTAL * `VID_V_TOTAL;
	// one c1 beat every second clk
	localparam int FRAME_CLKS = 2 * FRAME_BEATS;
	// clk period in ns
	localparam int CLK_NS = 4;

	logic         clk = 1'b0;
	logic         rst;
	render_mode_t render_mode;
	logic         hires;
	logic         nogfx;
	pal_index_t   border;
	logic [15:0]  frame_base;
	logic         mem_req;
	logic [15:0]  mem_addr;
	logic         mem_rvalid = 1'b0;
	logic [31:0]  mem_rdata = '0;
	logic         pal_we;
	pal_index_t   pal_addr;
	rgb_t         pal_wdata;
	logic         underrun;
	pal_index_t   vplex;
	logic         vplex_valid;
	rgb_t         rgb;
	logic         rgb_valid;

	// test table, one row per test
	string        t_name [NT];
	render_mode_t t_mode [NT];
	logic         t_hires [NT];
	logic         t_nogfx [NT];
	pal_index_t   t_border [NT];
	logic [15:0]  t_base [NT];
	int           t_frames [NT];
	int           t_lat_min [NT];
	int           t_lat_max [NT];
	logic         t_pal [NT];
	logic         t_starve [NT];
	int           frame_test [64];
	int           n_tests;
	int           total_frames;
	int           checks [NT];
	int           errors [NT];
	int           cur_test;

	// memory model state
	int          lat_min = 1;
	int          lat_max = 6;
	logic [15:0] mq_addr [$];
	int          mq_due [$];
	longint      mq_sent [$];
	int          cyc;
	int          outstanding;
	// replies handed out, time of their request and of the edge the FIFO takes them
	longint      rp_sent [$];
	longint      rp_push [$];

	// raster follower state
	int          beat;
	int          consumed;
	int          held_words;
	longint      flush_ns = 0;
	logic [31:0] cur_word;
	logic        cur_starved;
	logic [3:0]  prev_nib;
	rgb_t        rgb_exp;
	logic        rgb_known;
	logic        rgb_pending;
	rgb_t        pal_shadow [256];
	logic        pal_known [256];

	always #2 clk = ~clk;

	video_top dut0 (
		.clk(clk),
		.rst(rst),
		.render_mode(render_mode),
		.hires(hires),
		.nogfx(nogfx),
		.border(border),
		.frame_base(frame_base),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_rvalid(mem_rvalid),
		.mem_rdata(mem_rdata),
		.pal_we(pal_we),
		.pal_addr(pal_addr),
		.pal_wdata(pal_wdata),
		.underrun(underrun),
		.vplex(vplex),
		.vplex_valid(vplex_valid),
		.rgb(rgb),
		.rgb_valid(rgb_valid)
	);

	// memory contents, fixed scramble of the address
	function automatic logic [31:0] mem_word(input logic [15:0] addr);
		logic [31:0] x;
		x = {addr, addr ^ 16'hC3A5} * 32'h9E3779B1;
		return x ^ {x[14:0], x[31:15]};
	endfunction

	// psel units per video word
	function automatic int word_len(input render_mode_t mode);
		case (mode)
			rm_hc:   return 4;
			rm_xc:   return 2;
			default: return 16;
		endcase
	endfunction

	// expected vplex for one beat, hi-res packing included
	function automatic pal_index_t expected_index(input render_mode_t mode, input logic hires,
			input logic flash, input logic shown, input psel_t psel, input logic [31:0] word,
			input pal_index_t border_idx, input logic [3:0] prev);
		pal_index_t raw;
		logic [7:0] attr;
		logic       dot;
		int         b;
		// zx byte half, bitmap in the low 16 bits, attributes above
		b = int'(psel) / 8;
		attr = word[16 + 8 * b +: 8];
		// leftmost pixel is the msb of the byte
		dot = word[8 * b + 7 - int'(psel) % 8];
		if (!shown)
			raw = border_idx;
		else if (mode == rm_zx)
			raw = {zx_bank, attr[6], (dot ^ (flash & attr[7])) ? attr[2:0] : attr[5:3]};
		else if (mode == rm_tx)
			raw = {zx_bank, dot ? attr[3:0] : attr[7:4]};
		else if (mode == rm_hc)
			raw = {hc_bank, word[8 * (int'(psel) / 2) + 4 * (1 - int'(psel) % 2) +: 4]};
		else
			raw = word[8 * int'(psel) +: 8];
		return hires ? {prev, raw[3:0]} : raw;
	endfunction

	task automatic check_value(input int t, input string what, input int h, input int v,
			input logic [31:0] expected, input logic [31:0] actual);
		checks[t]++;
		if (expected !== actual) begin
			errors[t]++;
			$display("CHECK FAILED test %s %s at (%0d,%0d) expected %0h actual %0h",
				t_name[t], what, h, v, expected, actual);
		end
	endtask

	task automatic add_test(input string name, input render_mode_t mode, input logic hr,
			input logic ng, input pal_index_t bd, input logic [15:0] base, input int frames,
			input int lmin, input int lmax, input logic pal);
		int k;
		t_name[n_tests] = name;
		t_mode[n_tests] = mode;
		t_hires[n_tests] = hr;
		t_nogfx[n_tests] = ng;
		t_border[n_tests] = bd;
		t_base[n_tests] = base;
		t_frames[n_tests] = frames;
		t_lat_min[n_tests] = lmin;
		t_lat_max[n_tests] = lmax;
		t_pal[n_tests] = pal;
		// VID_CREDITS words per round trip cannot keep up with a 16c word every 8 clk
		t_starve[n_tests] = lmin > `VID_CREDITS * 8;
		for (k = 0; k < frames; k++) begin
			frame_test[total_frames] = n_tests;
			total_frames++;
		end
		n_tests++;
	endtask

	task automatic apply_test(input int t);
		render_mode <= t_mode[t];
		hires <= t_hires[t];
		nogfx <= t_nogfx[t];
		border <= t_border[t];
		frame_base <= t_base[t];
		lat_min <= t_lat_min[t];
		lat_max <= t_lat_max[t];
	endtask

	// all 256 entries, one write per clk
	task automatic load_palette();
		int i;
		for (i = 0; i < 256; i++) begin
			@(posedge clk);
			pal_we <= 1'b1;
			pal_addr <= pal_index_t'(i);
			pal_wdata <= rgb_t'(15'($urandom));
		end
		@(posedge clk);
		pal_we <= 1'b0;
	endtask

	// underrun only allowed in the starvation test
	task automatic report_test(input int t);
		check_value(t, "underrun", -1, -1, 32'(t_starve[t]), 32'(underrun));
		$display("test %0d %s done: %0d checks, %0d errors", t, t_name[t], checks[t], errors[t]);
	endtask

	// in-order replies, random latency, counts reads in flight
	always @(posedge clk) begin
		if (rst) begin
			mem_rvalid <= 1'b0;
			outstanding = 0;
		end else begin
			cyc = cyc + 1;
			if (mem_rvalid)
				outstanding = outstanding - 1;
			if (mq_addr.size() > 0 && mq_due[0] <= cyc) begin
				mem_rvalid <= 1'b1;
				mem_rdata <= mem_word(mq_addr.pop_front());
				void'(mq_due.pop_front());
				// the FIFO sees the reply one edge later
				rp_sent.push_back(mq_sent.pop_front());
				rp_push.push_back(longint'($time) + CLK_NS);
			end else begin
				mem_rvalid <= 1'b0;
			end
			if (mem_req) begin
				if (outstanding >= `VID_CREDITS) begin
					errors[cur_test]++;
					$display("ERROR test %s: memory request issued with no credit left",
						t_name[cur_test]);
				end
				outstanding = outstanding + 1;
				mq_addr.push_back(mem_addr);
				mq_due.push_back(cyc + lat_min + int'($urandom % 32'(lat_max - lat_min + 1)));
				mq_sent.push_back(longint'($time));
			end
		end
	end

	// follows the raster beat by beat from vplex_valid
	always @(posedge clk) begin : follow_raster
		int         f;
		int         p;
		int         h;
		int         v;
		int         a;
		int         t;
		int         step;
		int         bpw;
		logic       shown;
		psel_t      ps;
		pal_index_t exp_idx;
		longint     take_ns;
		if (!rst) begin
			if (rgb_valid && rgb_pending) begin
				if (rgb_known)
					check_value(cur_test, "rgb", -1, -1, 32'(rgb_exp), 32'(rgb));
				rgb_pending = 1'b0;
			end
			if (vplex_valid && beat < total_frames * FRAME_BEATS) begin
				f = beat / FRAME_BEATS;
				p = beat % FRAME_BEATS;
				h = p % `VID_H_TOTAL;
				v = p / `VID_H_TOTAL;
				t = frame_test[f];
				if (t != cur_test) begin
					report_test(cur_test);
					cur_test = t;
				end
				// fifo flushed at (0,0), words restart at the frame base
				if (p == 0) begin
					consumed = 0;
					held_words = 0;
					flush_ns = longint'($time) - CLK_NS;
				end
				step = t_hires[t] ? 2 : 1;
				bpw = word_len(t_mode[t]) / step;
				shown = 1'b0;
				ps = '0;
				if (h >= H_START && v < `VID_V_ACTIVE) begin
					a = h - H_START;
					ps = psel_t'((a % bpw) * step);
					if (a % bpw == 0) begin
						// take was one beat earlier, only replies pushed before it count
						take_ns = longint'($time) - 3 * CLK_NS;
						while (rp_push.size() > 0 && rp_push[0] < take_ns) begin
							// replies to requests from before the flush are dropped
							if (rp_sent.pop_front() > flush_ns)
								held_words++;
							void'(rp_push.pop_front());
						end
						// empty fifo at the take, border for the whole word
						cur_starved = held_words == 0;
						if (!cur_starved) begin
							held_words--;
							cur_word = mem_word(t_base[t] + 16'(consumed));
							consumed++;
						end
					end
					shown = !t_nogfx[t] && !cur_starved;
				end
				exp_idx = expected_index(t_mode[t], t_hires[t], 1'((f / `VID_FLASH_DIV) % 2),
					shown, ps, cur_word, t_border[t], prev_nib);
				check_value(t, "vplex", h, v, 32'(exp_idx), 32'(vplex));
				prev_nib = exp_idx[3:0];
				// palette reads the old entry on a same-cycle write
				rgb_exp = pal_shadow[exp_idx];
				rgb_known = pal_known[exp_idx];
				rgb_pending = 1'b1;
				beat++;
			end
			if (pal_we) begin
				pal_shadow[pal_addr] = pal_wdata;
				pal_known[pal_addr] = 1'b1;
			end
		end
	end

	initial begin : stimulus
		int i;
		int t;
		int waited;
		int all_checks;
		int all_errors;
		void'($urandom(92883));
		add_test("zx_frame", rm_zx, 1'b0, 1'b0, 8'h35, 16'h0100, 1, 1, 6, 1'b1);
		add_test("hc_frame", rm_hc, 1'b0, 1'b0, 8'h42, 16'h2000, 1, 1, 6, 1'b0);
		add_test("xc_frame", rm_xc, 1'b0, 1'b0, 8'h07, 16'h3000, 1, 1, 6, 1'b0);
		add_test("tx_frame", rm_tx, 1'b0, 1'b0, 8'h5A, 16'h4000, 1, 1, 6, 1'b0);
		add_test("nogfx", rm_xc, 1'b0, 1'b1, 8'h9C, 16'h5000, 1, 1, 6, 1'b0);
		// spans both flash phases
		add_test("zx_flash", rm_zx, 1'b0, 1'b0, 8'h11, 16'h6000, 4, 1, 6, 1'b0);
		add_test("hires", rm_hc, 1'b1, 1'b0, 8'h6B, 16'h7000, 1, 1, 6, 1'b0);
		add_test("palette", rm_xc, 1'b0, 1'b0, 8'h20, 16'h8000, 1, 1, 6, 1'b1);
		// border 00 never matches a 16c pixel, so starved words are visible
		add_test("underrun", rm_hc, 1'b0, 1'b0, 8'h00, 16'h9000, 2, 40, 40, 1'b0);
		for (i = 0; i < 256; i++)
			pal_known[i] = 1'b0;
		rst = 1'b1;
		render_mode = rm_zx;
		hires = 1'b0;
		nogfx = 1'b0;
		border = '0;
		frame_base = '0;
		pal_we = 1'b0;
		pal_addr = '0;
		pal_wdata = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		// each test starts on the edge just after the last beat of the previous frame
		for (t = 0; t < n_tests; t++) begin
			apply_test(t);
			waited = 0;
			if (t_pal[t]) begin
				load_palette();
				waited = 257;
			end
			repeat (t_frames[t] * FRAME_CLKS - waited) @(posedge clk);
		end
		// last vplex and rgb drain out
		repeat (4) @(posedge clk);
		#1;
		report_test(cur_test);
		if (beat != total_frames * FRAME_BEATS) begin
			errors[cur_test]++;
			$display("ERROR only %0d of %0d pixels were rendered", beat,
				total_frames * FRAME_BEATS);
		end
		all_checks = 0;
		all_errors = 0;
		for (t = 0; t < n_tests; t++) begin
			all_checks += checks[t];
			all_errors += errors[t];
		end
		$display("%0d tests, %0d checks, %0d errors", n_tests, all_checks, all_errors);
		if (all_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// frames of all tests plus reset and a few spare frames
	initial begin : watchdog
		int limit;
		#1;
		limit = (total_frames + 4) * FRAME_CLKS * 4 + 16 * 4;
		#(limit);
		$display("watchdog: run did not finish within %0d ns", limit);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule
